// ==== qbus_pkg.sv ====
// Widths and timing of the inverted multiplexed processor bus.
// ad_n carries the complement of address and data; strobes are active low.

package qbus_pkg;

   localparam int DATA_W = 16;                  // Bus word width
   localparam int ADDR_W = 16;                  // Byte address width

   // Clocks from a strobe first seen low to rply_n low
   localparam int REPLY_LAT = 3;

   typedef logic [DATA_W-1:0] data_t;           // One bus word, true polarity
   typedef logic [ADDR_W-1:0] addr_t;           // Byte address from the address phase

endpackage

// ==== slave_map_pkg.sv ====
// Address window of the RAM slave.
// WORDS must be a power of two, and the window must end at or below the top of
// the 16-bit byte address space. BASE_ADDR is expected to be word aligned.

package slave_map_pkg;

   localparam qbus_pkg::addr_t BASE_ADDR = 16'o100000;   // First byte of the window
   localparam int              WORDS     = 256;          // Words behind the window

   localparam int IDX_W     = $clog2(WORDS);    // Word index width
   localparam int WIN_BYTES = WORDS * 2;        // Window size in bytes

   // One past the last byte, one bit wider so a window at the top cannot wrap
   localparam logic [qbus_pkg::ADDR_W:0] WIN_END =
      (qbus_pkg::ADDR_W+1)'(BASE_ADDR) + (qbus_pkg::ADDR_W+1)'(WIN_BYTES);

   typedef logic [IDX_W-1:0] word_idx_t;        // Word index inside the window
   typedef logic [1:0]       byte_en_t;         // Bit 1 high lane, bit 0 low lane

endpackage

// ==== qbus_req_if.sv ====
// Decoded memory request from the cycle decoder to the memory stage.
// rd and wr are single-cycle pulses; payload is valid in the pulse cycle only.
`timescale 1ns/1ps

interface qbus_req_if;

   logic                      rd;               // Read request pulse
   logic                      wr;               // Write request pulse
   slave_map_pkg::word_idx_t  idx;              // Word inside the window
   slave_map_pkg::byte_en_t   byte_en;          // Lanes to write, 2'b11 on reads
   qbus_pkg::data_t           wdata;            // Write word, true polarity

   // No back-pressure, the memory takes one request per clock
   modport src (
      output rd,
      output wr,
      output idx,
      output byte_en,
      output wdata
   );

   modport dst (
      input  rd,
      input  wr,
      input  idx,
      input  byte_en,
      input  wdata
   );

endinterface

// ==== qbus_cycle_decode.sv ====
// Bus cycle front end. Inputs are taken as synchronous to clk_p, no synchronizers.
// One request per selected sync cycle; later strobes in the same cycle are ignored.
`timescale 1ns/1ps

module qbus_cycle_decode (
   input  logic            clk_p,
   input  logic            rst_n,
   input  logic            sync_n,              // Address strobe
   input  logic            din_n,               // Data input strobe
   input  logic            dout_n,              // Data output strobe
   input  logic            wtbt_n,              // Byte write when low in data phase
   input  qbus_pkg::data_t ad_in,               // Bus value, already un-inverted
   qbus_req_if.src         req
);

   logic                     sync_q;            // Strobe levels one edge back
   logic                     din_q;
   logic                     dout_q;
   logic                     sel_q;             // Cycle hits the window
   logic                     rd_pend;           // Strobe edge seen, issue next clock
   logic                     wr_pend;
   qbus_pkg::addr_t          addr_q;            // Latched byte address
   qbus_pkg::addr_t          offset;            // Byte offset into the window
   qbus_pkg::data_t          wdata_q;
   slave_map_pkg::byte_en_t  be_q;
   logic                     sync_fall;
   logic                     din_fall;
   logic                     dout_fall;
   logic                     in_win;

   assign sync_fall = sync_q & ~sync_n;
   assign din_fall  = din_q & ~din_n;
   assign dout_fall = dout_q & ~dout_n;

   // Window check on the live address, used only at the sync edge
   assign in_win = (ad_in >= slave_map_pkg::BASE_ADDR) &&
                   ({1'b0, ad_in} < slave_map_pkg::WIN_END);

   assign offset = addr_q - slave_map_pkg::BASE_ADDR;

   always_ff @(posedge clk_p or negedge rst_n) begin
      if (!rst_n) begin
         sync_q  <= 1'b1;                       // Bus idle is high
         din_q   <= 1'b1;
         dout_q  <= 1'b1;
         sel_q   <= 1'b0;
         rd_pend <= 1'b0;
         wr_pend <= 1'b0;
         req.rd  <= 1'b0;
         req.wr  <= 1'b0;
      end else begin
         sync_q  <= sync_n;
         din_q   <= din_n;
         dout_q  <= dout_n;
         rd_pend <= sel_q & din_fall;           // Read wins a double strobe
         wr_pend <= sel_q & dout_fall & ~din_fall;
         req.rd  <= rd_pend;                    // Out after edge k+1
         req.wr  <= wr_pend;
         if (sync_fall) begin
            sel_q <= in_win;                    // New cycle, new decision
         end else if (sync_n || din_fall || dout_fall) begin
            sel_q <= 1'b0;                      // Served or cycle over
         end
      end
   end

   // Payload, held until the next cycle overwrites it
   always_ff @(posedge clk_p) begin
      if (sync_fall) begin
         addr_q <= ad_in;
      end
      if (sel_q && (din_fall || dout_fall)) begin
         wdata_q <= ad_in;                      // Don't care on reads
         if (din_fall || wtbt_n) begin
            be_q <= 2'b11;                      // Whole word
         end else begin
            be_q <= addr_q[0] ? 2'b10 : 2'b01;  // Odd byte is high lane
         end
      end
   end

   assign req.idx     = offset[slave_map_pkg::IDX_W:1];
   assign req.byte_en = be_q;
   assign req.wdata   = wdata_q;

endmodule

// ==== qbus_mem_stage.sv ====
// On-chip word array with byte-lane writes.
// Contents are undefined after power-up; reset clears only the done pulses.
`timescale 1ns/1ps

module qbus_mem_stage (
   input  logic            clk_p,
   input  logic            rst_n,
   qbus_req_if.dst         req,
   output qbus_pkg::data_t rdata,               // Read word, valid with rd_done
   output logic            rd_done,             // One clock after req.rd
   output logic            wr_done              // One clock after req.wr
);

   localparam int HALF = qbus_pkg::DATA_W / 2;  // Lane width

   qbus_pkg::data_t mem [slave_map_pkg::WORDS];

   // Array and read register
   always_ff @(posedge clk_p) begin
      if (req.wr) begin
         if (req.byte_en[0]) begin
            mem[req.idx][HALF-1:0] <= req.wdata[HALF-1:0];       // Low lane
         end
         if (req.byte_en[1]) begin
            mem[req.idx][qbus_pkg::DATA_W-1:HALF] <=
               req.wdata[qbus_pkg::DATA_W-1:HALF];                // High lane
         end
      end
      if (req.rd) begin
         rdata <= mem[req.idx];
      end
   end

   // Completion pulses
   always_ff @(posedge clk_p or negedge rst_n) begin
      if (!rst_n) begin
         rd_done <= 1'b0;
         wr_done <= 1'b0;
      end else begin
         rd_done <= req.rd;                     // Out after edge k+2
         wr_done <= req.wr;
      end
   end

endmodule

// ==== qbus_reply_stage.sv ====
// Reply generator. Holds rply_n low until the master raises the active strobe.
// A done pulse arriving outside idle is dropped; the decoder never sends one.
`timescale 1ns/1ps

module qbus_reply_stage (
   input  logic            clk_p,
   input  logic            rst_n,
   input  logic            din_n,
   input  logic            dout_n,
   input  logic            rd_done,
   input  logic            wr_done,
   input  qbus_pkg::data_t rdata,
   output logic            rply_n,              // Active low reply
   output logic            ad_oe,               // Drive ad_n with read data
   output qbus_pkg::data_t ad_out               // Read word, true polarity
);

   typedef enum logic [1:0] {
      idle,
      reply_read,
      reply_write
   } state_t;

   state_t          state;
   qbus_pkg::data_t rdata_q;                    // Word on the bus during reply

   always_ff @(posedge clk_p or negedge rst_n) begin
      if (!rst_n) begin
         state <= idle;
      end else begin
         case (state)
            idle: begin
               if (rd_done) begin
                  state <= reply_read;          // Reply after edge k+3
               end else if (wr_done) begin
                  state <= reply_write;
               end
            end
            reply_read: begin
               if (din_n) state <= idle;        // Master took the data
            end
            reply_write: begin
               if (dout_n) state <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

   // Capture in the same edge that enters reply_read
   always_ff @(posedge clk_p) begin
      if (rd_done) begin
         rdata_q <= rdata;
      end
   end

   assign rply_n = (state == idle);
   assign ad_oe  = (state == reply_read);
   assign ad_out = rdata_q;

endmodule

// ==== qbus_ram_slave.sv ====
// RAM slave on the inverted multiplexed bus of the vm2 CPU.
// No interrupts, DMA or read-modify-write; out-of-window cycles get no reply.
`timescale 1ns/1ps

module qbus_ram_slave (
   input  logic        clk_p,                   // Processor clock, rising edge
   input  logic        rst_n,
   input  logic        sync_n,                  // Address strobe
   input  logic        din_n,                   // Data input strobe
   input  logic        dout_n,                  // Data output strobe
   input  logic        wtbt_n,                  // Write/byte status
   output logic        rply_n,                  // Transaction reply
   inout  logic [15:0] ad_n                     // Inverted address/data bus
);

   qbus_pkg::data_t ad_in;                      // Bus value, true polarity
   qbus_pkg::data_t ad_out;
   qbus_pkg::data_t rdata;
   logic            ad_oe;
   logic            rd_done;
   logic            wr_done;

   qbus_req_if req ();

   assign ad_in = ~ad_n;
   assign ad_n  = ad_oe ? ~ad_out : 'z;         // Released outside read reply

   qbus_cycle_decode u_decode (
      .clk_p  (clk_p),
      .rst_n  (rst_n),
      .sync_n (sync_n),
      .din_n  (din_n),
      .dout_n (dout_n),
      .wtbt_n (wtbt_n),
      .ad_in  (ad_in),
      .req    (req.src)
   );

   qbus_mem_stage u_mem (
      .clk_p   (clk_p),
      .rst_n   (rst_n),
      .req     (req.dst),
      .rdata   (rdata),
      .rd_done (rd_done),
      .wr_done (wr_done)
   );

   qbus_reply_stage u_reply (
      .clk_p   (clk_p),
      .rst_n   (rst_n),
      .din_n   (din_n),
      .dout_n  (dout_n),
      .rd_done (rd_done),
      .wr_done (wr_done),
      .rdata   (rdata),
      .rply_n  (rply_n),
      .ad_oe   (ad_oe),
      .ad_out  (ad_out)
   );

endmodule

// ==== qbus_ram_slave_sva.sv ====
// Bus protocol rules checked inside every qbus_ram_slave instance.
// sel_q comes from the decoder; sampled values trail the edge that sets them.
`timescale 1ns/1ps

module qbus_ram_slave_sva (
   input logic clk_p,
   input logic rst_n,
   input logic din_n,
   input logic dout_n,
   input logic rply_n,
   input logic ad_oe,                           // Slave drives ad_n
   input logic sel_q                            // Cycle hits the window
);

   int unsigned fail_count = 0;                 // Assertion failures so far

   // Reply only during a strobe or the edge that sees it end
   a_rply_in_strobe: assert property (@(posedge clk_p) disable iff (!rst_n)
      !rply_n |-> (!din_n || !dout_n || !$past(din_n) || !$past(dout_n)))
      else begin
         fail_count++;
         $error("rply_n low outside a data strobe");
      end

   a_drive_in_read: assert property (@(posedge clk_p) disable iff (!rst_n)
      ad_oe |-> (!din_n || !$past(din_n)))
      else begin
         fail_count++;
         $error("ad_n driven outside din_n");
      end

   // Change after edge k+3 shows in the sample at k+4
   a_reply_latency: assert property (@(posedge clk_p) disable iff (!rst_n)
      (sel_q && ($fell(din_n) || $fell(dout_n))) |->
         ##(qbus_pkg::REPLY_LAT + 1) $fell(rply_n))
      else begin
         fail_count++;
         $error("rply_n not low after REPLY_LAT");
      end

   a_reset_idle: assert property (@(posedge clk_p)
      !rst_n |=> rply_n)
      else begin
         fail_count++;
         $error("rply_n low after reset");
      end

endmodule

bind qbus_ram_slave qbus_ram_slave_sva u_sva (
   .clk_p  (clk_p),
   .rst_n  (rst_n),
   .din_n  (din_n),
   .dout_n (dout_n),
   .rply_n (rply_n),
   .ad_oe  (ad_oe),
   .sel_q  (u_decode.sel_q)
);

// ==== tb_qbus_ram_slave.sv ====
// Bus master testbench for the RAM slave. The whole window is written first,
// since the array holds no defined value after power-up.
`timescale 1ns/1ps

module tb_qbus_ram_slave;

   localparam int REPLY_TIMEOUT = 16;           // Clocks before a cycle counts as unanswered

   logic            clk_p;
   logic            rst_n;
   logic            sync_n;
   logic            din_n;
   logic            dout_n;
   logic            wtbt_n;
   logic            rply_n;
   logic [15:0]     ad_drv;                     // Master side of ad_n in bus polarity
   logic            ad_en;
   tri1  [15:0]     ad_n;                       // Released bus reads all ones

   qbus_pkg::data_t shadow [slave_map_pkg::WORDS];   // Reference memory
   int              err_count = 0;
   int              to_count  = 0;
   int              seed      = 49995;

   assign ad_n = ad_en ? ad_drv : 16'hzzzz;

   qbus_ram_slave dut (
      .clk_p  (clk_p),
      .rst_n  (rst_n),
      .sync_n (sync_n),
      .din_n  (din_n),
      .dout_n (dout_n),
      .wtbt_n (wtbt_n),
      .rply_n (rply_n),
      .ad_n   (ad_n)
   );

   initial begin
      clk_p = 1'b0;
      forever #20 clk_p = ~clk_p;
   end

   // Two bytes per word slot
   function automatic slave_map_pkg::word_idx_t word_of(qbus_pkg::addr_t a);
      return slave_map_pkg::word_idx_t'((a - slave_map_pkg::BASE_ADDR) >> 1);
   endfunction

   function automatic qbus_pkg::data_t fill_word(qbus_pkg::addr_t a);
      return {a[7:0], a[15:8]} ^ 16'h5a5a;      // Every address bit shows up
   endfunction

   task automatic model_write(qbus_pkg::addr_t a, qbus_pkg::data_t d, bit byte_w);
      if (!byte_w) shadow[word_of(a)] = d;
      else if (a[0]) shadow[word_of(a)][15:8] = d[15:8];  // Odd byte rides the high lane
      else shadow[word_of(a)][7:0] = d[7:0];
   endtask

   task automatic check_eq(qbus_pkg::addr_t a, qbus_pkg::data_t got, qbus_pkg::data_t exp);
      assert (got === exp) else begin
         err_count++;
         $display("** Error @%0t: read at %o returned %h, expected %h", $time, a, got, exp);
      end
   endtask

   // Counts edges after the strobe was driven; edge k is the first of them
   task automatic wait_reply(input string what, input qbus_pkg::addr_t a,
                             input bit expect_reply, output bit got);
      int edges;
      edges = 0;
      @(negedge clk_p);
      while (rply_n !== 1'b0 && edges < REPLY_TIMEOUT) begin
         @(negedge clk_p);
         edges++;
      end
      got = (rply_n === 1'b0);
      if (expect_reply && !got) begin
         to_count++;
         $display("Timeout: %s cycle at address %o got no reply within %0d clocks",
                  what, a, REPLY_TIMEOUT);
      end
      if (expect_reply && got) begin
         assert (edges - 1 == qbus_pkg::REPLY_LAT) else begin
            err_count++;
            $display("** Error @%0t: %s at %o replied %0d clocks after the strobe",
                     $time, what, a, edges - 1);
         end
      end
   endtask

   task automatic start_cycle(qbus_pkg::addr_t a);
      @(posedge clk_p);
      ad_drv <= ~a;                             // Address phase
      ad_en  <= 1'b1;
      sync_n <= 1'b0;
   endtask

   task automatic close_cycle(bit is_read);
      @(posedge clk_p);
      din_n  <= 1'b1;
      dout_n <= 1'b1;
      @(posedge clk_p);                         // Slave sees the strobe high here
      @(negedge clk_p);
      assert (rply_n === 1'b1 && (!is_read || ad_n === 16'hffff)) else begin
         err_count++;
         $display("** Error @%0t: reply or bus not released after the strobe", $time);
      end
      @(posedge clk_p);
      sync_n <= 1'b1;
      ad_en  <= 1'b0;
      wtbt_n <= 1'b1;
   endtask

   task automatic bus_write(qbus_pkg::addr_t a, qbus_pkg::data_t d, bit byte_w);
      bit got;
      start_cycle(a);
      @(posedge clk_p);
      ad_drv <= ~d;
      wtbt_n <= ~byte_w;
      dout_n <= 1'b0;
      wait_reply("write", a, 1'b1, got);
      close_cycle(1'b0);
      model_write(a, d, byte_w);
   endtask

   task automatic bus_read(input qbus_pkg::addr_t a, output qbus_pkg::data_t d);
      bit got;
      start_cycle(a);
      @(posedge clk_p);
      ad_en <= 1'b0;                            // Slave owns the bus now
      din_n <= 1'b0;
      wait_reply("read", a, 1'b1, got);
      d = ~ad_n;                                // Sampled mid-cycle while rply_n is low
      close_cycle(1'b1);
   endtask

   task automatic read_check(qbus_pkg::addr_t a);
      qbus_pkg::data_t d;
      bus_read(a, d);
      check_eq(a, d, shadow[word_of(a)]);
   endtask

   // Write and read outside the window get no answer
   task automatic bus_probe(qbus_pkg::addr_t a);
      bit got;
      start_cycle(a);
      @(posedge clk_p);
      ad_drv <= ~16'h5aa5;
      dout_n <= 1'b0;
      wait_reply("probe write", a, 1'b0, got);
      assert (!got) else begin
         err_count++;
         $display("** Error @%0t: write at %o outside the window got a reply", $time, a);
      end
      close_cycle(1'b0);
      start_cycle(a);
      @(posedge clk_p);
      ad_en <= 1'b0;
      din_n <= 1'b0;
      wait_reply("probe read", a, 1'b0, got);
      assert (!got) else begin
         err_count++;
         $display("** Error @%0t: read at %o outside the window got a reply", $time, a);
      end
      close_cycle(1'b1);
   endtask

   initial begin
      qbus_pkg::addr_t a;
      qbus_pkg::data_t d;
      int              kind;
      int              total;
      rst_n  <= 1'b0;
      sync_n <= 1'b1;
      din_n  <= 1'b1;
      dout_n <= 1'b1;
      wtbt_n <= 1'b1;
      ad_en  <= 1'b0;
      ad_drv <= '0;
      repeat (5) @(posedge clk_p);
      rst_n <= 1'b1;
      @(negedge clk_p);
      assert (rply_n === 1'b1 && ad_n === 16'hffff) else begin
         err_count++;
         $display("** Error @%0t: slave not idle after reset", $time);
      end
      for (int i = 0; i < slave_map_pkg::WORDS; i++) begin
         a = slave_map_pkg::BASE_ADDR + qbus_pkg::addr_t'(2 * i);
         bus_write(a, fill_word(a), 1'b0);
      end
      a = slave_map_pkg::BASE_ADDR + 16'o10;    // Word write and read back
      bus_write(a, 16'h1234, 1'b0);
      bus_read(a, d);
      check_eq(a, d, 16'h1234);
      bus_write(a, 16'h00ab, 1'b1);             // Low lane only
      bus_read(a, d);
      check_eq(a, d, 16'h12ab);
      bus_write(a + 1, 16'hcd00, 1'b1);         // High lane only
      bus_read(a, d);
      check_eq(a, d, 16'hcdab);
      bus_probe(slave_map_pkg::BASE_ADDR - 2);
      bus_probe(slave_map_pkg::BASE_ADDR + qbus_pkg::addr_t'(slave_map_pkg::WIN_BYTES));
      bus_probe(16'o0);
      bus_probe(16'o177776);
      read_check(slave_map_pkg::BASE_ADDR);     // Aliases of the probed addresses
      read_check(slave_map_pkg::BASE_ADDR + qbus_pkg::addr_t'(slave_map_pkg::WIN_BYTES - 2));
      repeat (200) begin
         kind = $random(seed) & 3;
         a = slave_map_pkg::BASE_ADDR +
             qbus_pkg::addr_t'($random(seed) & (slave_map_pkg::WIN_BYTES - 1));
         d = qbus_pkg::data_t'($random(seed));
         case (kind)
            0: read_check({a[15:1], 1'b0});
            1: bus_write({a[15:1], 1'b0}, d, 1'b0);
            default: bus_write(a, d, 1'b1);
         endcase
      end
      for (int i = 0; i < slave_map_pkg::WORDS; i++) begin
         read_check(slave_map_pkg::BASE_ADDR + qbus_pkg::addr_t'(2 * i));
      end
      total = err_count + to_count + int'(dut.u_sva.fail_count);
      $display("Errors: %0d value, %0d timeout, %0d assertion",
               err_count, to_count, dut.u_sva.fail_count);
      if (total == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== qbus_ram_slave.f ====
qbus_pkg.sv
slave_map_pkg.sv
qbus_req_if.sv
qbus_cycle_decode.sv
qbus_mem_stage.sv
qbus_reply_stage.sv
qbus_ram_slave.sv
qbus_ram_slave_sva.sv
tb_qbus_ram_slave.sv

// ==== Bender.yml ====
package:
  name: qbus_ram_slave

sources:
  - qbus_pkg.sv
  - slave_map_pkg.sv
  - qbus_req_if.sv
  - qbus_cycle_decode.sv
  - qbus_mem_stage.sv
  - qbus_reply_stage.sv
  - qbus_ram_slave.sv
  - target: test
    files:
      - qbus_ram_slave_sva.sv
      - tb_qbus_ram_slave.sv
